//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_ec_dbl -Mdir obj_dir
	./obj_dir/Vtb_ec_dbl | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_ec_dbl.sv
// Testbench for ec_dbl_top, random points checked against a wide-integer doubling model
// Stimulus from a 32-bit xorshift with a fixed seed, curve coefficient a taken as 0
// Inputs driven and outputs sampled DLY after each rising edge
`include "ec_config.svh"

module tb_ec_dbl;
  import ec_pkg::*;

  localparam int     TIMEOUT = 2000;  // Cycles allowed per wait
  localparam int     DLY     = 10;    // Offset after posedge
  localparam longint P       = `EC_PRIME;

  logic        i_clk;
  logic        i_rst;
  jpoint_t     i_p;
  logic        i_val;
  logic        o_rdy;
  jpoint_t     o_p;
  logic        o_val;
  logic        i_rdy;
  logic [31:0] rng;     // Xorshift state
  int          checks;
  int          errors;
  bit          hung;    // Some wait ran out, later tests are skipped

  ec_dbl_top dut0 (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_p(i_p), .i_val(i_val), .o_rdy(o_rdy),
    .o_p(o_p), .o_val(o_val), .i_rdy(i_rdy)
  );

  always #50 i_clk = ~i_clk;  // Period 100

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic fe_t rand_fe();
    rng = xorshift32(rng);
    return fe_t'(rng % `EC_PRIME);  // Reduced below the prime
  endfunction

  function automatic jpoint_t rand_point(input bit inf);
    jpoint_t p;
    p.x = rand_fe();
    p.y = rand_fe();
    p.z = inf ? '0 : rand_fe();
    if (!inf && p.z == '0) p.z = fe_t'(1);  // Keep finite points finite
    return p;
  endfunction

  function automatic longint mod_mul(input longint a, input longint b);
    return (a * b) % P;  // Operands below 2**17, no overflow
  endfunction

  // Reference doubling, X3 = D^2-8xy^2, Y3 = D(4xy^2-X3)-8y^4, Z3 = 2yz
  function automatic jpoint_t dbl_model(input jpoint_t p);
    longint  x, y, z, a, b, c, d, x3, y3, z3;
    jpoint_t r;
    if (p.z == '0) return p;  // Infinity passes through
    x  = longint'(p.x);
    y  = longint'(p.y);
    z  = longint'(p.z);
    a  = mod_mul(y, y);
    b  = mod_mul(4, mod_mul(x, a));
    c  = mod_mul(8, mod_mul(a, a));
    d  = mod_mul(3, mod_mul(x, x));
    x3 = (mod_mul(d, d) + 2 * P - 2 * b) % P;
    y3 = (mod_mul(d, (b - x3 + P) % P) - c + P) % P;
    z3 = mod_mul(mod_mul(2, y), z);
    r.x = fe_t'(x3);
    r.y = fe_t'(y3);
    r.z = fe_t'(z3);
    return r;
  endfunction

  task automatic check_point(input jpoint_t got, input jpoint_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: %s, got (%h,%h,%h) expected (%h,%h,%h)", $time, what,
               got.x, got.y, got.z, exp.x, exp.y, exp.z);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report(input string name, input int err0);
    if (errors == err0) $display("test %-12s ok", name);
    else $display("test %-12s %0d errors", name, errors - err0);
  endtask

  // Offer a point until o_rdy takes it, optionally leave i_val high afterwards
  task automatic send_point(input jpoint_t p, input bit hold_val, output bit ok);
    bit taken;
    int n;
    taken = 1'b0;
    n     = 0;
    i_p   = p;
    i_val = 1'b1;
    while (!taken && n < TIMEOUT) begin
      taken = o_rdy;  // Registered, so it is the value at the coming edge
      @(posedge i_clk);
      #DLY;
      n++;
    end
    if (!hold_val || !taken) i_val = 1'b0;
    ok = taken;
    if (!taken) begin
      hung = 1'b1;
      errors++;
      $display("Timeout at %0t: DUT never raised o_rdy to accept a point", $time);
    end
  endtask

  task automatic wait_result(output jpoint_t p, output bit ok);
    int n;
    n = 0;
    while (!o_val && n < TIMEOUT) begin
      @(posedge i_clk);
      #DLY;
      n++;
    end
    ok = o_val;
    p  = o_p;
    if (!ok) begin
      hung = 1'b1;
      errors++;
      $display("Timeout at %0t: DUT gave no answer, o_val never rose", $time);
    end
  endtask

  task automatic test_reset();
    int err0;
    int n;
    err0  = errors;
    i_rst = 1'b1;
    repeat (4) begin
      @(posedge i_clk);
      #DLY;
      check_flag(o_val, 1'b0, "o_val during reset");
      check_flag(o_rdy, 1'b0, "o_rdy during reset");
    end
    i_rst = 1'b0;
    n = 0;
    while (!o_rdy && n < TIMEOUT) begin
      @(posedge i_clk);
      #DLY;
      n++;
    end
    if (!o_rdy) begin
      hung = 1'b1;
      errors++;
      $display("Timeout at %0t: DUT gave no answer, o_rdy stayed low after reset", $time);
    end
    report("reset", err0);
  endtask

  task automatic run_random(input int count, input bit inf, input string name);
    jpoint_t p;
    jpoint_t got;
    bit      ok;
    int      err0;
    err0 = errors;
    for (int k = 0; k < count && !hung; k++) begin
      p = rand_point(inf);
      send_point(p, 1'b0, ok);
      if (ok && inf) check_flag(o_val, 1'b1, "o_val one cycle after accepting z = 0");
      if (ok) wait_result(got, ok);
      if (ok) begin
        check_point(got, dbl_model(p), name);
        @(posedge i_clk);  // Transfer out, i_rdy is high
        #DLY;
      end
    end
    report(name, err0);
  endtask

  task automatic run_backpressure(input int count);
    jpoint_t p;
    jpoint_t got;
    bit      ok;
    int      err0;
    int      stall;
    err0 = errors;
    for (int k = 0; k < count && !hung; k++) begin
      p     = rand_point(1'b0);
      i_rdy = 1'b0;
      send_point(p, 1'b0, ok);
      if (ok) wait_result(got, ok);
      if (ok) begin
        rng   = xorshift32(rng);
        stall = 1 + int'(rng % 20);
        repeat (stall) begin
          @(posedge i_clk);
          #DLY;
          check_flag(o_val, 1'b1, "o_val held under back-pressure");
          check_flag(o_rdy, 1'b0, "o_rdy low while result pending");
          check_point(o_p, got, "o_p stable under back-pressure");
        end
        i_rdy = 1'b1;
        @(posedge i_clk);
        #DLY;
        check_flag(o_val, 1'b0, "o_val drops after transfer");
        check_point(got, dbl_model(p), "back-pressure result");
      end
    end
    i_rdy = 1'b1;
    report("backpressure", err0);
  endtask

  // i_val and i_rdy stay high, next point waits on the bus during each run
  task automatic run_back_to_back(input int count);
    jpoint_t cur;
    jpoint_t nxt;
    jpoint_t got;
    bit      ok;
    int      err0;
    err0  = errors;
    i_rdy = 1'b1;
    cur   = rand_point(1'b0);
    send_point(cur, 1'b1, ok);
    for (int k = 0; k < count && ok; k++) begin
      nxt = rand_point(1'b0);
      i_p = nxt;
      wait_result(got, ok);
      if (ok) begin
        check_point(got, dbl_model(cur), "back-to-back result");
        @(posedge i_clk);
        #DLY;
        check_flag(o_val, 1'b0, "single o_val per point");
        cur = nxt;
        if (k < count - 1) send_point(cur, 1'b1, ok);
      end
    end
    i_val = 1'b0;
    report("back-to-back", err0);
  endtask

  initial begin
    i_clk  = 1'b0;
    i_rst  = 1'b1;
    i_p    = '0;
    i_val  = 1'b0;
    i_rdy  = 1'b1;
    rng    = 32'd47;
    checks = 0;
    errors = 0;
    hung   = 1'b0;
    test_reset();
    if (!hung) run_random(200, 1'b0, "random");
    if (!hung) run_random(50, 1'b1, "infinity");
    if (!hung) run_backpressure(30);
    if (!hung) run_back_to_back(40);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- hw/ec_dbl_top.sv
// Jacobian point doubler, one shared multiplier plus an adder and a subtractor
// Latency varies with the unit mix, o_val marks the result
`include "ec_config.svh"

module ec_dbl_top (
  input  logic            i_clk,
  input  logic            i_rst,
  input  ec_pkg::jpoint_t i_p,
  input  logic            i_val,
  output logic            o_rdy,
  output ec_pkg::jpoint_t o_p,
  output logic            o_val,
  input  logic            i_rdy
);
  import ec_pkg::*;

  // Issue and result links, one set per unit
  logic   mul_val, mul_rdy, mul_res_val, mul_res_rdy;
  fe_t    mul_a, mul_b, mul_res;
  eq_id_t mul_tag, mul_res_tag;
  logic   add_val, add_rdy, add_res_val, add_res_rdy;
  fe_t    add_a, add_b, add_res;
  eq_id_t add_tag, add_res_tag;
  logic   sub_val, sub_rdy, sub_res_val, sub_res_rdy;
  fe_t    sub_a, sub_b, sub_res;
  eq_id_t sub_tag, sub_res_tag;

  ec_point_dbl u_dbl (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_p(i_p), .i_val(i_val), .o_rdy(o_rdy),
    .o_p(o_p), .o_val(o_val), .i_rdy(i_rdy),
    .o_mul_val(mul_val), .i_mul_rdy(mul_rdy), .o_mul_a(mul_a), .o_mul_b(mul_b),
    .o_mul_tag(mul_tag), .i_mul_res_val(mul_res_val), .o_mul_res_rdy(mul_res_rdy),
    .i_mul_res(mul_res), .i_mul_tag(mul_res_tag),
    .o_add_val(add_val), .i_add_rdy(add_rdy), .o_add_a(add_a), .o_add_b(add_b),
    .o_add_tag(add_tag), .i_add_res_val(add_res_val), .o_add_res_rdy(add_res_rdy),
    .i_add_res(add_res), .i_add_tag(add_res_tag),
    .o_sub_val(sub_val), .i_sub_rdy(sub_rdy), .o_sub_a(sub_a), .o_sub_b(sub_b),
    .o_sub_tag(sub_tag), .i_sub_res_val(sub_res_val), .o_sub_res_rdy(sub_res_rdy),
    .i_sub_res(sub_res), .i_sub_tag(sub_res_tag)
  );

  fp_mod_mul u_mul (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(mul_val), .o_rdy(mul_rdy),
    .i_a(mul_a), .i_b(mul_b), .i_tag(mul_tag),
    .o_res_val(mul_res_val), .i_res_rdy(mul_res_rdy),
    .o_res(mul_res), .o_tag(mul_res_tag)
  );

  fp_mod_addsub #(.SUBTRACT(`EC_ADDSUB_ADD)) u_add (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(add_val), .o_rdy(add_rdy),
    .i_a(add_a), .i_b(add_b), .i_tag(add_tag),
    .o_res_val(add_res_val), .i_res_rdy(add_res_rdy),
    .o_res(add_res), .o_tag(add_res_tag)
  );

  fp_mod_addsub #(.SUBTRACT(`EC_ADDSUB_SUB)) u_sub (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(sub_val), .o_rdy(sub_rdy),
    .i_a(sub_a), .i_b(sub_b), .i_tag(sub_tag),
    .o_res_val(sub_res_val), .i_res_rdy(sub_res_rdy),
    .o_res(sub_res), .o_tag(sub_res_tag)
  );

endmodule

//--- hw/ec_pkg.sv
// Types and constants for Jacobian doubling over the small prime field
// Curve coefficient a is taken as 0, so no constant for it
`include "ec_config.svh"

package ec_pkg;

  typedef logic [`EC_WIDTH-1:0] fe_t;  // Always reduced below EC_PRIME

  typedef struct packed {
    fe_t x;
    fe_t y;
    fe_t z;
  } jpoint_t;

  // Doubling equations, each value is also its bit in the scheduler masks
  typedef enum logic [`EC_TAG_BITS-1:0] {
    EQ_A_SQ = 0,  // A = y^2
    EQ_B_MUL,     // B = x*A
    EQ_B_X4,      // B = 4*B
    EQ_C_SQ,      // C = A^2
    EQ_C_X8,      // C = 8*C
    EQ_D_SQ,      // D = x^2
    EQ_D_X3,      // D = 3*D
    EQ_X_SQ,      // X3 = D^2
    EQ_E_DBL,     // E = B+B
    EQ_X_SUB,     // X3 = X3-E
    EQ_Y_SUB,     // Y3 = B-X3
    EQ_Y_MUL,     // Y3 = D*Y3
    EQ_Y_FIN,     // Y3 = Y3-C
    EQ_Z_DBL,     // Z3 = y+y
    EQ_Z_MUL      // Z3 = Z3*z
  } eq_id_t;

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} dbl_state_t;

  // Small multipliers, valid as is since nothing is in Montgomery form
  localparam fe_t FE_THREE = 3;
  localparam fe_t FE_FOUR  = 4;
  localparam fe_t FE_EIGHT = 8;

endpackage

//--- hw/ec_point_dbl.sv
// Dataflow scheduler for Jacobian point doubling, curve coefficient a = 0
// Input with z = 0 is the point at infinity and is returned unchanged
// Units must return each tag exactly once, in any order
module ec_point_dbl (
  input  logic            i_clk,
  input  logic            i_rst,
  // Point in
  input  ec_pkg::jpoint_t i_p,
  input  logic            i_val,
  output logic            o_rdy,
  // Point out
  output ec_pkg::jpoint_t o_p,
  output logic            o_val,
  input  logic            i_rdy,
  // Multiplier
  output logic            o_mul_val,
  input  logic            i_mul_rdy,
  output ec_pkg::fe_t     o_mul_a,
  output ec_pkg::fe_t     o_mul_b,
  output ec_pkg::eq_id_t  o_mul_tag,
  input  logic            i_mul_res_val,
  output logic            o_mul_res_rdy,
  input  ec_pkg::fe_t     i_mul_res,
  input  ec_pkg::eq_id_t  i_mul_tag,
  // Adder
  output logic            o_add_val,
  input  logic            i_add_rdy,
  output ec_pkg::fe_t     o_add_a,
  output ec_pkg::fe_t     o_add_b,
  output ec_pkg::eq_id_t  o_add_tag,
  input  logic            i_add_res_val,
  output logic            o_add_res_rdy,
  input  ec_pkg::fe_t     i_add_res,
  input  ec_pkg::eq_id_t  i_add_tag,
  // Subtractor
  output logic            o_sub_val,
  input  logic            i_sub_rdy,
  output ec_pkg::fe_t     o_sub_a,
  output ec_pkg::fe_t     o_sub_b,
  output ec_pkg::eq_id_t  o_sub_tag,
  input  logic            i_sub_res_val,
  output logic            o_sub_res_rdy,
  input  ec_pkg::fe_t     i_sub_res,
  input  ec_pkg::eq_id_t  i_sub_tag
);
  import ec_pkg::*;

  localparam int NUM_EQ = 15;

  typedef struct packed {
    logic   go;
    eq_id_t id;
    fe_t    a;
    fe_t    b;
  } issue_t;

  dbl_state_t        state;
  logic [NUM_EQ-1:0] eq_wait;  // Issued to a unit
  logic [NUM_EQ-1:0] eq_done;  // Result written back
  jpoint_t           p_in;     // Latched input point
  fe_t               tmp_a, tmp_b, tmp_c, tmp_d, tmp_e;
  issue_t            mul_req, add_req, sub_req;
  logic              in_fire;
  logic              mul_fire, add_fire, sub_fire;

  assign in_fire  = i_val && o_rdy;  // o_rdy is only high in ST_IDLE
  assign mul_fire = i_mul_res_val && o_mul_res_rdy;
  assign add_fire = i_add_res_val && o_add_res_rdy;
  assign sub_fire = i_sub_res_val && o_sub_res_rdy;

  // Results only come back while running
  assign o_mul_res_rdy = (state == ST_RUN);
  assign o_add_res_rdy = (state == ST_RUN);
  assign o_sub_res_rdy = (state == ST_RUN);

  function automatic issue_t req(input eq_id_t id, input fe_t a, input fe_t b);
    issue_t r;
    r.go = 1'b1;
    r.id = id;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // Fixed priority pick per unit, slot is free when empty or being taken
  always_comb begin
    mul_req = '0;
    if (state == ST_RUN && (~o_mul_val | i_mul_rdy)) begin
      if (!eq_wait[EQ_A_SQ])
        mul_req = req(EQ_A_SQ, p_in.y, p_in.y);
      else if (eq_done[EQ_A_SQ] && !eq_wait[EQ_B_MUL])
        mul_req = req(EQ_B_MUL, p_in.x, tmp_a);
      else if (eq_done[EQ_A_SQ] && !eq_wait[EQ_C_SQ])
        mul_req = req(EQ_C_SQ, tmp_a, tmp_a);
      else if (!eq_wait[EQ_D_SQ])
        mul_req = req(EQ_D_SQ, p_in.x, p_in.x);
      else if (eq_done[EQ_D_SQ] && !eq_wait[EQ_D_X3])
        mul_req = req(EQ_D_X3, FE_THREE, tmp_d);
      else if (eq_done[EQ_D_X3] && !eq_wait[EQ_X_SQ])
        mul_req = req(EQ_X_SQ, tmp_d, tmp_d);
      else if (eq_done[EQ_Y_SUB] && eq_done[EQ_D_X3] && !eq_wait[EQ_Y_MUL])
        mul_req = req(EQ_Y_MUL, tmp_d, o_p.y);
      else if (eq_done[EQ_Z_DBL] && !eq_wait[EQ_Z_MUL])
        mul_req = req(EQ_Z_MUL, p_in.z, o_p.z);
      else if (eq_done[EQ_B_MUL] && !eq_wait[EQ_B_X4])
        mul_req = req(EQ_B_X4, tmp_b, FE_FOUR);
      else if (eq_done[EQ_C_SQ] && !eq_wait[EQ_C_X8])
        mul_req = req(EQ_C_X8, tmp_c, FE_EIGHT);
    end
  end

  always_comb begin
    sub_req = '0;
    if (state == ST_RUN && (~o_sub_val | i_sub_rdy)) begin
      if (eq_done[EQ_E_DBL] && eq_done[EQ_X_SQ] && !eq_wait[EQ_X_SUB])
        sub_req = req(EQ_X_SUB, o_p.x, tmp_e);
      else if (eq_done[EQ_X_SUB] && eq_done[EQ_B_X4] && !eq_wait[EQ_Y_SUB])
        sub_req = req(EQ_Y_SUB, tmp_b, o_p.x);
      else if (eq_done[EQ_C_X8] && eq_done[EQ_Y_MUL] && !eq_wait[EQ_Y_FIN])
        sub_req = req(EQ_Y_FIN, o_p.y, tmp_c);
    end
  end

  always_comb begin
    add_req = '0;
    if (state == ST_RUN && (~o_add_val | i_add_rdy)) begin
      if (eq_done[EQ_B_X4] && !eq_wait[EQ_E_DBL])
        add_req = req(EQ_E_DBL, tmp_b, tmp_b);
      else if (!eq_wait[EQ_Z_DBL])
        add_req = req(EQ_Z_DBL, p_in.y, p_in.y);
    end
  end

  // Control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      eq_wait   <= '0;
      eq_done   <= '0;
      o_mul_val <= 1'b0;
      o_add_val <= 1'b0;
      o_sub_val <= 1'b0;
    end else begin
      if (i_mul_rdy) o_mul_val <= 1'b0;  // Taken by the unit
      if (i_add_rdy) o_add_val <= 1'b0;
      if (i_sub_rdy) o_sub_val <= 1'b0;
      if (mul_req.go) begin
        o_mul_val           <= 1'b1;
        eq_wait[mul_req.id] <= 1'b1;
      end
      if (add_req.go) begin
        o_add_val           <= 1'b1;
        eq_wait[add_req.id] <= 1'b1;
      end
      if (sub_req.go) begin
        o_sub_val           <= 1'b1;
        eq_wait[sub_req.id] <= 1'b1;
      end
      if (mul_fire) eq_done[i_mul_tag] <= 1'b1;
      if (add_fire) eq_done[i_add_tag] <= 1'b1;
      if (sub_fire) eq_done[i_sub_tag] <= 1'b1;

      case (state)
        ST_IDLE: begin
          o_rdy <= 1'b1;
          if (in_fire) begin
            o_rdy   <= 1'b0;
            eq_wait <= '0;
            eq_done <= '0;
            if (i_p.z == '0) begin  // Point at infinity, skip the math
              o_val <= 1'b1;
              state <= ST_DONE;
            end else begin
              state <= ST_RUN;
            end
          end
        end
        ST_RUN: begin
          if (&eq_done) begin  // Every equation back, nothing left in flight
            o_val <= 1'b1;
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (i_rdy) begin
            o_val <= 1'b0;
            o_rdy <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operands, temporaries and output coordinates
  always_ff @(posedge i_clk) begin
    if (in_fire) begin
      p_in <= i_p;
      o_p  <= i_p;  // Kept as is for z = 0, overwritten otherwise
    end
    if (mul_req.go) begin
      o_mul_a   <= mul_req.a;
      o_mul_b   <= mul_req.b;
      o_mul_tag <= mul_req.id;
    end
    if (add_req.go) begin
      o_add_a   <= add_req.a;
      o_add_b   <= add_req.b;
      o_add_tag <= add_req.id;
    end
    if (sub_req.go) begin
      o_sub_a   <= sub_req.a;
      o_sub_b   <= sub_req.b;
      o_sub_tag <= sub_req.id;
    end
    if (mul_fire) begin
      case (i_mul_tag)
        EQ_A_SQ:          tmp_a <= i_mul_res;
        EQ_B_MUL, EQ_B_X4: tmp_b <= i_mul_res;
        EQ_C_SQ, EQ_C_X8: tmp_c <= i_mul_res;
        EQ_D_SQ, EQ_D_X3: tmp_d <= i_mul_res;
        EQ_X_SQ:          o_p.x <= i_mul_res;
        EQ_Y_MUL:         o_p.y <= i_mul_res;
        EQ_Z_MUL:         o_p.z <= i_mul_res;
        default: ;
      endcase
    end
    if (add_fire) begin
      case (i_add_tag)
        EQ_E_DBL: tmp_e <= i_add_res;
        EQ_Z_DBL: o_p.z <= i_add_res;
        default: ;
      endcase
    end
    if (sub_fire) begin
      case (i_sub_tag)
        EQ_X_SUB:           o_p.x <= i_sub_res;
        EQ_Y_SUB, EQ_Y_FIN: o_p.y <= i_sub_res;
        default: ;
      endcase
    end
  end

endmodule

//--- hw/fp_mod_addsub.sv
// One-cycle modular adder or subtractor, SUBTRACT picks the operation
// Inputs must be below EC_PRIME, streams one item per cycle
`include "ec_config.svh"

module fp_mod_addsub #(
  parameter int SUBTRACT = `EC_ADDSUB_ADD
) (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_val,
  output logic           o_rdy,
  input  ec_pkg::fe_t    i_a,
  input  ec_pkg::fe_t    i_b,
  input  ec_pkg::eq_id_t i_tag,
  output logic           o_res_val,
  input  logic           i_res_rdy,
  output ec_pkg::fe_t    o_res,
  output ec_pkg::eq_id_t o_tag
);
  import ec_pkg::*;

  localparam logic [`EC_WIDTH:0] PRIME = (`EC_WIDTH + 1)'(`EC_PRIME);

  logic [`EC_WIDTH:0] raw;       // Extra bit is carry or borrow
  fe_t                res_next;
  logic               in_fire;

  assign o_rdy   = ~o_res_val | i_res_rdy;  // Empty, or draining this cycle
  assign in_fire = i_val && o_rdy;

  always_comb begin
    if (SUBTRACT == `EC_ADDSUB_SUB) begin
      raw      = {1'b0, i_a} - {1'b0, i_b};
      res_next = raw[`EC_WIDTH] ? fe_t'(raw + PRIME) : fe_t'(raw);  // Borrow, add p back
    end else begin
      raw      = {1'b0, i_a} + {1'b0, i_b};
      res_next = (raw >= PRIME) ? fe_t'(raw - PRIME) : fe_t'(raw);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) o_res_val <= 1'b0;
    else if (in_fire) o_res_val <= 1'b1;
    else if (i_res_rdy) o_res_val <= 1'b0;
  end

  // Result and tag hold under back-pressure
  always_ff @(posedge i_clk) begin
    if (in_fire) begin
      o_res <= res_next;
      o_tag <= i_tag;
    end
  end

endmodule

//--- hw/fp_mod_mul.sv
// Bit-serial modular multiplier, one bit of i_b per cycle from the MSB
// Both operands must already be below EC_PRIME
// Result valid EC_WIDTH+1 cycles after acceptance, one item in flight
`include "ec_config.svh"

module fp_mod_mul (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_val,
  output logic           o_rdy,
  input  ec_pkg::fe_t    i_a,
  input  ec_pkg::fe_t    i_b,
  input  ec_pkg::eq_id_t i_tag,
  output logic           o_res_val,
  input  logic           i_res_rdy,
  output ec_pkg::fe_t    o_res,
  output ec_pkg::eq_id_t o_tag
);
  import ec_pkg::*;

  typedef enum logic [1:0] {MUL_IDLE, MUL_WORK, MUL_HOLD} mul_state_t;

  localparam int CNT_W = $clog2(`EC_WIDTH + 1);
  localparam logic [`EC_WIDTH:0] PRIME = (`EC_WIDTH + 1)'(`EC_PRIME);

  mul_state_t         state;
  logic [CNT_W-1:0]   bit_cnt;       // Bits consumed so far
  fe_t                a_q;           // Multiplicand
  fe_t                b_q;           // Multiplier, shifted left each step
  fe_t                acc;           // Partial product, kept reduced
  logic [`EC_WIDTH:0] dbl_sum;
  logic [`EC_WIDTH:0] add_sum;
  fe_t                dbl_red;
  fe_t                acc_next;
  logic               in_fire;

  assign in_fire   = i_val && o_rdy;
  assign o_rdy     = (state == MUL_IDLE);
  assign o_res_val = (state == MUL_HOLD);

  // One interleaved step: acc = 2*acc + bit*a, reduced twice
  always_comb begin
    dbl_sum  = {acc, 1'b0};  // Below 2p, one subtract is enough
    dbl_red  = (dbl_sum >= PRIME) ? fe_t'(dbl_sum - PRIME) : fe_t'(dbl_sum);
    add_sum  = {1'b0, dbl_red} + (b_q[`EC_WIDTH-1] ? {1'b0, a_q} : '0);
    acc_next = (add_sum >= PRIME) ? fe_t'(add_sum - PRIME) : fe_t'(add_sum);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= MUL_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          bit_cnt <= '0;
          if (in_fire) state <= MUL_WORK;
        end
        MUL_WORK: begin
          if (bit_cnt == CNT_W'(`EC_WIDTH)) state <= MUL_HOLD;  // Extra cycle loads o_res
          else bit_cnt <= bit_cnt + 1'b1;
        end
        MUL_HOLD: if (i_res_rdy) state <= MUL_IDLE;  // Hold until taken
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge i_clk) begin
    if (in_fire) begin
      a_q   <= i_a;
      b_q   <= i_b;
      acc   <= '0;
      o_tag <= i_tag;  // Tag rides along unchanged
    end else if (state == MUL_WORK) begin
      if (bit_cnt == CNT_W'(`EC_WIDTH)) begin
        o_res <= acc;
      end else begin
        acc <= acc_next;
        b_q <= b_q << 1;
      end
    end
  end

endmodule

//--- include/ec_config.svh
// Field and unit settings shared by the doubler RTL and the testbench
// EC_PRIME must be odd and below 2**EC_WIDTH, values are plain residues
`ifndef EC_CONFIG_SVH
`define EC_CONFIG_SVH

// Field element width and modulus
`define EC_WIDTH 16
`define EC_PRIME 65521

// Equation tag width, must hold all fifteen doubling equations
`define EC_TAG_BITS 4

// Mode values for the SUBTRACT parameter of fp_mod_addsub
`define EC_ADDSUB_ADD 0
`define EC_ADDSUB_SUB 1

`endif

//--- project.f
+incdir+include
hw/ec_pkg.sv
hw/fp_mod_mul.sv
hw/fp_mod_addsub.sv
hw/ec_point_dbl.sv
hw/ec_dbl_top.sv
bench/tb_ec_dbl.sv
